//--- design/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero_flag,    // a == b, for beq / bne
    output logic    less_than     // signed a < b, for blt / bge
);

    word_t                    diff;
    logic [$clog2(xlen)-1:0] shamt;      // low bits of b only

    assign diff      = operand_a - operand_b;
    assign shamt     = operand_b[$clog2(xlen)-1:0];
    assign zero_flag = (diff == '0);
    assign less_than = ($signed(operand_a) < $signed(operand_b));

    always_comb begin
        case (op)
            alu_add:    result = operand_a + operand_b;
            alu_sub:    result = diff;
            alu_and:    result = operand_a & operand_b;
            alu_or:     result = operand_a | operand_b;
            alu_xor:    result = operand_a ^ operand_b;
            alu_sll:    result = operand_a << shamt;
            alu_srl:    result = operand_a >> shamt;
            alu_sra:    result = word_t'($signed(operand_a) >>> shamt);   // sign fill
            alu_slt:    result = {{(xlen-1){1'b0}}, less_than};
            alu_sltu:   result = {{(xlen-1){1'b0}}, (operand_a < operand_b)};
            alu_pass_b: result = operand_b;                              // lui immediate
            default:    result = '0;
        endcase
    end

endmodule

//--- design/cpu_pkg.sv
package cpu_pkg;

    // ========================================================================
    // widths
    // ========================================================================
    localparam int unsigned xlen       = 32;     // data and instruction width
    localparam int unsigned reg_addr_w = 5;      // 32 architectural registers
    localparam int unsigned dmem_words = 256;    // data ram depth in words

    typedef logic [xlen-1:0]               word_t;
    typedef logic [reg_addr_w-1:0]         reg_addr_t;
    typedef logic [$clog2(dmem_words)-1:0] dmem_addr_t;   // word index, not byte

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    // ========================================================================
    // rv32i major opcodes, instr[6:0]
    // ========================================================================
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;   // only ecall is decoded

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,        // also drives the branch compare
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b      // lui
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus_4    // jal link value
    } wb_sel_t;

endpackage

//--- design/data_memory.sv
`timescale 1ns/1ps

module data_memory import cpu_pkg::*; (
    input  logic       clk,
    input  dmem_addr_t addr,        // word index
    input  logic       wr_en,
    input  word_t      wr_data,
    output word_t      rd_data
);

    word_t mem [dmem_words];

    // async read so a load can forward out of the memory stage
    assign rd_data = mem[addr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;   // whole words only
        end
    end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t  rs1_d,
    input  reg_addr_t  rs2_d,
    input  reg_addr_t  rs1_e,
    input  reg_addr_t  rs2_e,
    input  reg_addr_t  rd_m,
    input  reg_addr_t  rd_w,
    input  logic       rf_wr_en_m,
    input  logic       rf_wr_en_w,
    input  logic       is_branch_e,
    input  logic [1:0] branch_kind_e,
    input  logic       jump_e,
    input  logic       zero_flag,
    input  logic       less_than,
    output fwd_sel_t   fwd_a,
    output fwd_sel_t   fwd_b,
    output logic       bypass_a,     // decode reads the reg being written back
    output logic       bypass_b,
    output logic       redirect,     // pc takes the branch target
    output logic       flush         // younger two instructions become bubbles
);

    logic taken;

    // youngest producer wins, memory stage before writeback
    function automatic fwd_sel_t pick_src(reg_addr_t rs);
        if (rf_wr_en_m && rd_m == rs)
            return fwd_from_mem;
        if (rf_wr_en_w && rd_w == rs)
            return fwd_from_wb;
        return fwd_none;
    endfunction

    always_comb begin
        fwd_a = pick_src(rs1_e);
        fwd_b = pick_src(rs2_e);
    end

    // rf write lands at the clock edge, decode needs it now
    assign bypass_a = rf_wr_en_w && (rd_w == rs1_d);
    assign bypass_b = rf_wr_en_w && (rd_w == rs2_d);

    always_comb begin
        case (branch_kind_e)
            2'b00:   taken = zero_flag;      // beq
            2'b01:   taken = ~zero_flag;     // bne
            2'b10:   taken = less_than;      // blt
            default: taken = ~less_than;     // bge
        endcase
    end

    assign redirect = (is_branch_e && taken) || jump_e;
    assign flush    = redirect;

endmodule

//--- design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import cpu_pkg::*; (
    input  word_t     instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm,
    output alu_op_t   alu_op,
    output logic      use_imm,      // alu b operand from imm
    output logic      is_branch,
    output logic [1:0] branch_kind, // eq, ne, lt, ge
    output logic      jump,
    output logic      mem_wr_en,
    output wb_sel_t   wb_sel,
    output logic      rf_wr_en,
    output logic      is_halt
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_fn;           // instr[30] picks sub / sra
    logic       writes_rd;        // opcode has a destination
    alu_op_t    arith_op;         // funct3 decode shared by reg and imm forms

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt_fn = instr[30];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // beq 000, bne 001, blt 100, bge 101 fold onto two bits
    assign branch_kind = {funct3[2], funct3[0]};

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op_reg && alt_fn) ? alu_sub : alu_add;  // no subi
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt_fn ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        // defaults form a bubble
        imm       = '0;
        alu_op    = alu_add;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        jump      = 1'b0;
        mem_wr_en = 1'b0;
        wb_sel    = wb_alu;
        writes_rd = 1'b0;
        is_halt   = 1'b0;
        case (opcode)
            op_reg: begin
                alu_op    = arith_op;
                writes_rd = 1'b1;
            end
            op_imm: begin
                imm       = {{20{instr[31]}}, instr[31:20]};           // i-type
                alu_op    = arith_op;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            op_lui: begin
                imm       = {instr[31:12], 12'b0};                      // u-type
                alu_op    = alu_pass_b;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            op_load: begin
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_imm   = 1'b1;                                       // base + offset
                wb_sel    = wb_mem;
                writes_rd = 1'b1;
            end
            op_store: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // s-type
                use_imm   = 1'b1;
                mem_wr_en = 1'b1;
            end
            op_branch: begin
                imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};                        // b-type
                alu_op    = alu_sub;                                    // flags from a - b
                is_branch = ~funct3[1];                                 // unsigned forms not kept
            end
            op_jal: begin
                imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};                       // j-type
                jump      = 1'b1;
                wb_sel    = wb_pc_plus_4;
                writes_rd = 1'b1;
            end
            op_system: is_halt = 1'b1;
            default: ;                                                  // unknown opcode is a nop
        endcase
    end

    // x0 is never written, so nothing downstream checks for it
    assign rf_wr_en = writes_rd && (rd != '0);

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [2**reg_addr_w];

    // reads are combinational, decode sees them the same cycle
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // entry 0 is cleared here and the decoder never sends a write to it,
    // so x0 stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;     // writeback stage
        end
    end

endmodule

//--- design/riscv_cpu.sv
`timescale 1ns/1ps

module riscv_cpu import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     instr,        // returned for pc in the same cycle
    output word_t     pc,
    output logic      rf_wr_en,
    output reg_addr_t rf_wr_addr,
    output word_t     rf_wr_data,
    output logic      halt          // sticky until reset
);

    // stage suffixes d=decode e=execute m=memory w=writeback
    word_t      instr_d, pc_d;
    reg_addr_t  rs1_d, rs2_d, rd_d;
    word_t      imm_d, rs1_data_d, rs2_data_d, rs1_val_d, rs2_val_d;
    alu_op_t    alu_op_d;
    logic       use_imm_d, is_branch_d, jump_d, mem_wr_en_d, rf_wr_en_d, is_halt_d;
    logic [1:0] branch_kind_d;
    wb_sel_t    wb_sel_d;

    word_t      pc_e, imm_e, rs1_data_e, rs2_data_e;
    reg_addr_t  rs1_e, rs2_e, rd_e;
    alu_op_t    alu_op_e;
    logic       use_imm_e, is_branch_e, jump_e, mem_wr_en_e, rf_wr_en_e, halt_e;
    logic [1:0] branch_kind_e;
    wb_sel_t    wb_sel_e;
    word_t      src_a_e, src_b_e, alu_result_e;   // after forwarding
    logic       zero_flag, less_than;
    fwd_sel_t   fwd_a, fwd_b;
    logic       bypass_a, bypass_b, redirect, flush;

    word_t      alu_m, rs2_data_m, pc_plus_4_m, dmem_rd_data, fwd_val_m;
    reg_addr_t  rd_m;
    logic       mem_wr_en_m, rf_wr_en_m, halt_m;
    wb_sel_t    wb_sel_m;

    word_t      alu_w, mem_data_w, pc_plus_4_w, wb_data_w;
    reg_addr_t  rd_w;
    logic       rf_wr_en_w, halt_w;
    wb_sel_t    wb_sel_w;

    // ========================================================================
    // fetch
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)        pc <= '0;
        else if (redirect) pc <= pc_e + imm_e;       // branch / jal target
        else               pc <= pc + 32'd4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_d <= '0;
            pc_d    <= '0;
        end else begin
            instr_d <= flush ? nop_instr : instr;   // kill the wrong-path fetch
            pc_d    <= pc;
        end
    end

    // ========================================================================
    // decode
    // ========================================================================
    instr_decoder u_decoder (
        .instr(instr_d), .rs1(rs1_d), .rs2(rs2_d), .rd(rd_d), .imm(imm_d),
        .alu_op(alu_op_d), .use_imm(use_imm_d), .is_branch(is_branch_d),
        .branch_kind(branch_kind_d), .jump(jump_d), .mem_wr_en(mem_wr_en_d),
        .wb_sel(wb_sel_d), .rf_wr_en(rf_wr_en_d), .is_halt(is_halt_d)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_d), .rs2_addr(rs2_d), .rs1_data(rs1_data_d), .rs2_data(rs2_data_d),
        .wr_en(rf_wr_en_w), .wr_addr(rd_w), .wr_data(wb_data_w)
    );

    assign rs1_val_d = bypass_a ? wb_data_w : rs1_data_d;   // wb to decode bypass
    assign rs2_val_d = bypass_b ? wb_data_w : rs2_data_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_e          <= '0;
            imm_e         <= '0;
            rs1_data_e    <= '0;
            rs2_data_e    <= '0;
            rs1_e         <= '0;
            rs2_e         <= '0;
            rd_e          <= '0;
            alu_op_e      <= alu_add;
            use_imm_e     <= 1'b1;
            wb_sel_e      <= wb_alu;
            is_branch_e   <= 1'b0;
            branch_kind_e <= '0;
            jump_e        <= 1'b0;
            mem_wr_en_e   <= 1'b0;
            rf_wr_en_e    <= 1'b0;
            halt_e        <= 1'b0;
        end else begin
            pc_e          <= pc_d;
            imm_e         <= imm_d;
            rs1_data_e    <= rs1_val_d;
            rs2_data_e    <= rs2_val_d;
            rs1_e         <= rs1_d;
            rs2_e         <= rs2_d;
            rd_e          <= rd_d;
            alu_op_e      <= alu_op_d;
            use_imm_e     <= use_imm_d;
            wb_sel_e      <= wb_sel_d;
            branch_kind_e <= branch_kind_d;
            // flushed slot carries a bubble, no side effects
            is_branch_e   <= is_branch_d && !flush;
            jump_e        <= jump_d && !flush;
            mem_wr_en_e   <= mem_wr_en_d && !flush;
            rf_wr_en_e    <= rf_wr_en_d && !flush;
            halt_e        <= is_halt_d && !flush;
        end
    end

    // ========================================================================
    // execute
    // ========================================================================
    always_comb begin
        case (fwd_a)
            fwd_from_mem: src_a_e = fwd_val_m;
            fwd_from_wb:  src_a_e = wb_data_w;
            default:      src_a_e = rs1_data_e;
        endcase
        case (fwd_b)
            fwd_from_mem: src_b_e = fwd_val_m;
            fwd_from_wb:  src_b_e = wb_data_w;
            default:      src_b_e = rs2_data_e;   // also the store data
        endcase
    end

    alu u_alu (
        .operand_a(src_a_e), .operand_b(use_imm_e ? imm_e : src_b_e), .op(alu_op_e),
        .result(alu_result_e), .zero_flag(zero_flag), .less_than(less_than)
    );

    hazard_unit u_hazard (
        .rs1_d(rs1_d), .rs2_d(rs2_d), .rs1_e(rs1_e), .rs2_e(rs2_e),
        .rd_m(rd_m), .rd_w(rd_w), .rf_wr_en_m(rf_wr_en_m), .rf_wr_en_w(rf_wr_en_w),
        .is_branch_e(is_branch_e), .branch_kind_e(branch_kind_e), .jump_e(jump_e),
        .zero_flag(zero_flag), .less_than(less_than),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .bypass_a(bypass_a), .bypass_b(bypass_b),
        .redirect(redirect), .flush(flush)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_m       <= '0;
            rs2_data_m  <= '0;
            pc_plus_4_m <= '0;
            rd_m        <= '0;
            mem_wr_en_m <= 1'b0;
            rf_wr_en_m  <= 1'b0;
            halt_m      <= 1'b0;
            wb_sel_m    <= wb_alu;
        end else begin
            alu_m       <= alu_result_e;
            rs2_data_m  <= src_b_e;
            pc_plus_4_m <= pc_e + 32'd4;
            rd_m        <= rd_e;
            mem_wr_en_m <= mem_wr_en_e;
            rf_wr_en_m  <= rf_wr_en_e;
            halt_m      <= halt_e;
            wb_sel_m    <= wb_sel_e;
        end
    end

    // ========================================================================
    // memory
    // ========================================================================
    data_memory u_dmem (
        .clk(clk), .addr(alu_m[9:2]), .wr_en(mem_wr_en_m),    // byte addr to word index
        .wr_data(rs2_data_m), .rd_data(dmem_rd_data)
    );

    // value this stage will write back, forwarded to execute
    always_comb begin
        case (wb_sel_m)
            wb_mem:       fwd_val_m = dmem_rd_data;   // load-use without a stall
            wb_pc_plus_4: fwd_val_m = pc_plus_4_m;
            default:      fwd_val_m = alu_m;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_w       <= '0;
            mem_data_w  <= '0;
            pc_plus_4_w <= '0;
            rd_w        <= '0;
            rf_wr_en_w  <= 1'b0;
            halt_w      <= 1'b0;
            wb_sel_w    <= wb_alu;
        end else begin
            alu_w       <= alu_m;
            mem_data_w  <= dmem_rd_data;
            pc_plus_4_w <= pc_plus_4_m;
            rd_w        <= rd_m;
            rf_wr_en_w  <= rf_wr_en_m;
            wb_sel_w    <= wb_sel_m;
            halt_w      <= halt_w | halt_m;           // holds once ecall arrives
        end
    end

    // ========================================================================
    // writeback
    // ========================================================================
    always_comb begin
        case (wb_sel_w)
            wb_mem:       wb_data_w = mem_data_w;
            wb_pc_plus_4: wb_data_w = pc_plus_4_w;    // jal link
            default:      wb_data_w = alu_w;
        endcase
    end

    assign rf_wr_en   = rf_wr_en_w;
    assign rf_wr_addr = rd_w;
    assign rf_wr_data = wb_data_w;
    assign halt       = halt_w;

endmodule

//--- riscv_cpu.f
design/cpu_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/alu.sv
design/hazard_unit.sv
design/data_memory.sv
design/riscv_cpu.sv
test/wb_checker.sv
test/riscv_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the riscv_cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module riscv_cpu_tb \
    -f riscv_cpu.f -o riscv_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/riscv_cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

//--- test/riscv_cpu_tb.sv
`timescale 1ns/1ps

module riscv_cpu_tb import cpu_pkg::*; ();

    localparam int n_tests    = 5;
    localparam int max_len    = 32;
    localparam int max_wr     = 24;
    localparam int imem_words = 64;
    localparam word_t ecall_w = 32'h0000_0073;

    logic      clk;
    logic      rst_n;
    word_t     instr;
    word_t     pc;
    logic      rf_wr_en;
    reg_addr_t rf_wr_addr;
    word_t     rf_wr_data;
    logic      halt;

    word_t     prog [n_tests][max_len];     // program words per test
    int        plen [n_tests];
    reg_addr_t wr_rd [n_tests][max_wr];     // expected writes per test
    word_t     wr_val [n_tests][max_wr];
    int        wr_cnt [n_tests];
    string     names [n_tests];
    word_t     imem [imem_words];           // instruction memory model
    int        cycles      = 0;
    int        cycle_limit = 100000;

    riscv_cpu UUT (
        .clk(clk), .rst_n(rst_n), .instr(instr), .pc(pc),
        .rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data), .halt(halt)
    );

    wb_checker chk (
        .clk(clk), .rst_n(rst_n), .rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr),
        .rf_wr_data(rf_wr_data), .halt(halt)
    );

    assign instr = imem[pc[7:2]];   // fetch answers in the same cycle

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, halt not reached after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ========================================================================
    // rv32i encoders
    // ========================================================================
    function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                     logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t lw(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                     logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};   // lui
    endfunction

    function automatic word_t j_type(reg_addr_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_instr(input int t, input word_t w);
        prog[t][plen[t]] = w;
        plen[t]++;
    endtask

    // instruction plus the register write it must produce
    task automatic add_instr_wr(input int t, input word_t w, input reg_addr_t rd,
                                input word_t val);
        add_instr(t, w);
        wr_rd[t][wr_cnt[t]]  = rd;
        wr_val[t][wr_cnt[t]] = val;
        wr_cnt[t]++;
    endtask

    // ========================================================================
    // program table, values worked from the isa by hand
    // ========================================================================
    task automatic build_tables();
        for (int t = 0; t < n_tests; t++) begin
            plen[t]   = 0;
            wr_cnt[t] = 0;
        end
        names[0] = "alu_chain";
        add_instr_wr(0, u_type(1, 20'h12345), 1, 32'h12345000);
        add_instr_wr(0, i_type(0, 2, 1, 12'h678), 2, 32'h12345678);
        add_instr_wr(0, r_type(0, 0, 3, 2, 1), 3, 32'h2468a678);
        add_instr_wr(0, r_type(7'h20, 0, 4, 3, 1), 4, 32'h12345678);    // sub
        add_instr_wr(0, r_type(0, 7, 5, 4, 3), 5, 32'h00200678);
        add_instr_wr(0, r_type(0, 6, 6, 5, 2), 6, 32'h12345678);
        add_instr_wr(0, r_type(0, 4, 7, 6, 3), 7, 32'h365cf000);
        add_instr_wr(0, i_type(1, 8, 7, 12'h002), 8, 32'hd973c000);      // slli
        add_instr_wr(0, i_type(5, 9, 8, 12'h004), 9, 32'h0d973c00);      // srli
        add_instr_wr(0, i_type(5, 10, 8, 12'h404), 10, 32'hfd973c00);    // srai
        add_instr_wr(0, i_type(0, 11, 0, 12'h008), 11, 32'h8);
        add_instr_wr(0, r_type(0, 1, 12, 10, 11), 12, 32'h973c0000);
        add_instr_wr(0, r_type(0, 5, 13, 12, 11), 13, 32'h00973c00);
        add_instr_wr(0, r_type(7'h20, 5, 14, 12, 11), 14, 32'hff973c00); // sra
        add_instr_wr(0, r_type(0, 2, 15, 14, 13), 15, 32'h1);
        add_instr_wr(0, r_type(0, 3, 16, 14, 13), 16, 32'h0);
        add_instr_wr(0, i_type(2, 17, 14, 12'h000), 17, 32'h1);
        add_instr_wr(0, i_type(3, 18, 13, 12'hfff), 18, 32'h1);          // sltiu vs all ones
        add_instr_wr(0, i_type(6, 19, 15, 12'h070), 19, 32'h71);
        add_instr_wr(0, i_type(7, 20, 19, 12'h030), 20, 32'h30);
        add_instr(0, ecall_w);

        names[1] = "decode_bypass";
        add_instr_wr(1, i_type(0, 1, 0, 12'd5), 1, 32'd5);
        add_instr_wr(1, i_type(0, 2, 0, 12'd7), 2, 32'd7);
        add_instr_wr(1, i_type(0, 3, 0, 12'd9), 3, 32'd9);
        add_instr_wr(1, r_type(0, 0, 4, 1, 1), 4, 32'd10);    // x1 from three back
        add_instr_wr(1, r_type(0, 0, 5, 2, 2), 5, 32'd14);
        add_instr_wr(1, r_type(0, 0, 6, 3, 4), 6, 32'd19);
        add_instr(1, ecall_w);

        names[2] = "mem_round_trip";
        add_instr_wr(2, i_type(0, 1, 0, 12'h055), 1, 32'h55);
        add_instr_wr(2, u_type(2, 20'habcde), 2, 32'habcde000);
        add_instr(2, sw(1, 0, 12'd16));
        add_instr(2, sw(2, 0, 12'd20));
        add_instr_wr(2, lw(3, 0, 12'd16), 3, 32'h55);
        add_instr_wr(2, r_type(0, 0, 4, 3, 3), 4, 32'haa);    // load-use right behind
        add_instr_wr(2, lw(5, 0, 12'd20), 5, 32'habcde000);
        add_instr_wr(2, r_type(0, 0, 6, 5, 4), 6, 32'habcde0aa);
        add_instr(2, ecall_w);

        names[3] = "branches";
        add_instr_wr(3, i_type(0, 1, 0, 12'd3), 1, 32'd3);
        add_instr_wr(3, i_type(0, 2, 0, 12'd5), 2, 32'd5);
        add_instr(3, b_type(3'b000, 1, 1, 13'd12));            // beq taken
        add_instr(3, i_type(0, 10, 0, 12'd1));
        add_instr(3, i_type(0, 11, 0, 12'd1));
        add_instr_wr(3, i_type(0, 3, 0, 12'h11), 3, 32'h11);
        add_instr(3, b_type(3'b001, 1, 1, 13'd12));            // bne not taken
        add_instr_wr(3, i_type(0, 12, 0, 12'd2), 12, 32'd2);
        add_instr_wr(3, i_type(0, 13, 0, 12'd3), 13, 32'd3);
        add_instr(3, b_type(3'b100, 1, 2, 13'd12));            // blt taken
        add_instr(3, i_type(0, 14, 0, 12'd1));
        add_instr(3, i_type(0, 15, 0, 12'd1));
        add_instr_wr(3, i_type(0, 4, 0, 12'h22), 4, 32'h22);
        add_instr(3, b_type(3'b101, 1, 2, 13'd12));            // bge not taken
        add_instr_wr(3, i_type(0, 16, 0, 12'd4), 16, 32'd4);
        add_instr_wr(3, i_type(0, 17, 0, 12'd5), 17, 32'd5);
        add_instr(3, b_type(3'b001, 1, 2, 13'd12));            // bne taken
        add_instr(3, i_type(0, 18, 0, 12'd1));
        add_instr(3, i_type(0, 19, 0, 12'd1));
        add_instr_wr(3, i_type(0, 5, 0, 12'h33), 5, 32'h33);
        add_instr(3, b_type(3'b101, 2, 1, 13'd12));            // bge taken
        add_instr(3, i_type(0, 24, 0, 12'd1));
        add_instr(3, i_type(0, 25, 0, 12'd1));
        add_instr_wr(3, i_type(0, 6, 0, 12'h44), 6, 32'h44);
        add_instr(3, b_type(3'b000, 1, 2, 13'd12));            // beq not taken
        add_instr_wr(3, i_type(0, 20, 0, 12'd6), 20, 32'd6);
        add_instr_wr(3, i_type(0, 21, 0, 12'd7), 21, 32'd7);
        add_instr(3, b_type(3'b100, 2, 1, 13'd12));            // blt not taken
        add_instr_wr(3, i_type(0, 22, 0, 12'd8), 22, 32'd8);
        add_instr_wr(3, i_type(0, 23, 0, 12'd9), 23, 32'd9);
        add_instr(3, ecall_w);

        names[4] = "jal_and_x0";
        add_instr_wr(4, i_type(0, 1, 0, 12'd1), 1, 32'd1);
        add_instr_wr(4, j_type(5, 21'd12), 5, 32'd8);          // link is pc+4
        add_instr(4, i_type(0, 6, 0, 12'd1));
        add_instr(4, i_type(0, 7, 0, 12'd1));
        add_instr_wr(4, i_type(0, 2, 5, 12'd1), 2, 32'd9);
        add_instr(4, i_type(0, 0, 0, 12'h7ff));                // addi to x0, no write
        add_instr(4, j_type(0, 21'd8));
        add_instr(4, i_type(0, 8, 0, 12'd1));
        add_instr_wr(4, r_type(0, 0, 3, 2, 0), 3, 32'd9);
        add_instr(4, ecall_w);
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < imem_words; i++)
            imem[i] = (i < plen[t]) ? prog[t][i] : nop_instr;
        chk.begin_test(names[t]);
        for (int k = 0; k < wr_cnt[t]; k++)
            chk.expect_write(wr_rd[t][k], wr_val[t][k]);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (halt !== 1'b1)
            @(posedge clk);
        @(negedge clk);
        chk.finish_test();
    endtask

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < imem_words; i++)
            imem[i] = nop_instr;
        build_tables();
        cycle_limit = 0;
        for (int t = 0; t < n_tests; t++)
            cycle_limit += plen[t] + 13;       // 10 spare plus reset per test
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        chk.print_counts();
        if (chk.error_count() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- test/wb_checker.sv
`timescale 1ns/1ps

module wb_checker import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rf_wr_en,
    input  reg_addr_t rf_wr_addr,
    input  word_t     rf_wr_data,
    input  logic      halt
);

    reg_addr_t exp_rd [$];      // expected writes, program order
    word_t     exp_val [$];
    string     test_name;
    int        test_errs    = 0;
    int        total_errs   = 0;
    int        tests_run    = 0;
    int        tests_failed = 0;
    logic      rst_q        = 1'b0;   // rst_n seen on the previous edge
    logic      halt_q       = 1'b0;   // halt seen high on the previous edge

    task automatic begin_test(input string name);
        exp_rd.delete();
        exp_val.delete();
        test_name = name;
        test_errs = 0;
    endtask

    task automatic expect_write(input reg_addr_t rd, input word_t val);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
    endtask

    task automatic flag_error(input string msg);
        $display("Error t=%0t %s", $time, msg);
        test_errs++;
        total_errs++;
    endtask

    // ========================================================================
    // writeback watch, outputs are registered so the edge sees settled values
    // ========================================================================
    always @(posedge clk) begin
        if (rst_n && rf_wr_en) begin
            if (halt)
                flag_error("register write seen after halt");
            if (rf_wr_addr == '0)
                flag_error("write reported to x0");
            if (exp_rd.size() == 0) begin
                flag_error($sformatf("extra write to x%0d", rf_wr_addr));
            end else begin
                if (rf_wr_addr !== exp_rd[0]) begin
                    $display("Fail t=%0t rf_wr_addr expected %0d got %0d",
                             $time, exp_rd[0], rf_wr_addr);
                    test_errs++;
                    total_errs++;
                end
                if (rf_wr_data !== exp_val[0]) begin
                    $display("Fail t=%0t rf_wr_data expected %h got %h",
                             $time, exp_val[0], rf_wr_data);
                    test_errs++;
                    total_errs++;
                end
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    // ========================================================================
    // reset leaves rf_wr_en and halt low, halt holds until the next reset
    // ========================================================================
    always @(posedge clk) begin
        if (rst_n && !rst_q) begin
            if (rf_wr_en !== 1'b0) begin
                $display("Fail t=%0t rf_wr_en expected 0 got %b", $time, rf_wr_en);
                test_errs++;
                total_errs++;
            end
            if (halt !== 1'b0) begin
                $display("Fail t=%0t halt expected 0 got %b", $time, halt);
                test_errs++;
                total_errs++;
            end
        end
        if (rst_n && halt_q && halt !== 1'b1)
            flag_error("halt dropped before reset");
        rst_q  = rst_n;
        halt_q = rst_n && (halt === 1'b1);
    end

    // called once halt is up
    task automatic finish_test();
        if (exp_rd.size() != 0)
            flag_error($sformatf("%0d expected writes missing at halt", exp_rd.size()));
        tests_run++;
        if (test_errs != 0)
            tests_failed++;
        $display("test %0d %s: %s (%0d errors)", tests_run, test_name,
                 (test_errs == 0) ? "ok" : "bad", test_errs);
    endtask

    task automatic print_counts();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errs);
    endtask

    function automatic int error_count();
        return total_errs;
    endfunction

endmodule
